// File: hdl/ahb_master_pkg.sv
package ahb_master_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int FIFO_DEPTH = 16;   // Also the longest burst
    localparam int CNT_W      = 5;
    localparam int BEAT_BYTES = 4;    // Word transfers only

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [3:0]        beat_cnt_t;
    typedef logic [CNT_W-1:0]  fifo_cnt_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    // Burst code on the request side
    typedef enum logic [1:0] {
        BURST_SINGLE = 2'd0,
        BURST_INCR4  = 2'd1,
        BURST_INCR8  = 2'd2,
        BURST_INCR16 = 2'd3
    } burst_code_e;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef logic [2:0] hburst_t;

    localparam hburst_t HBURST_SINGLE = 3'b000;
    localparam hburst_t HBURST_INCR4  = 3'b011;
    localparam hburst_t HBURST_INCR8  = 3'b101;
    localparam hburst_t HBURST_INCR16 = 3'b111;

    localparam logic [2:0] HSIZE_WORD = 3'b010;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////
    typedef struct packed {
        addr_t       addr;
        logic        write;    // High for a write
        burst_code_e burst;
    } ahb_req_t;

    typedef struct packed {
        addr_t      haddr;
        htrans_e    htrans;
        hburst_t    hburst;
        logic [2:0] hsize;
        logic       hwrite;
        logic       hmastlock;
    } ahb_addr_phase_t;

endpackage

// File: hdl/ahb_req_regs.sv
module ahb_req_regs (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_start,
    input  ahb_master_pkg::ahb_req_t i_req,
    input  logic                    i_beat_adv,
    output ahb_master_pkg::addr_t   o_addr,
    output logic                    o_write,
    output ahb_master_pkg::hburst_t o_hburst,
    output logic                    o_last_beat
);
    import ahb_master_pkg::*;

    addr_t     addr_q;
    logic      write_q;
    hburst_t   hburst_q;
    beat_cnt_t beat_q;       // Index of the beat in address phase
    beat_cnt_t last_q;       // Index of the final beat
    hburst_t   hburst_map;
    beat_cnt_t last_map;

    // Burst code to bus encoding and final beat index
    always_comb begin
        case (i_req.burst)
            BURST_INCR4: begin
                hburst_map = HBURST_INCR4;
                last_map   = beat_cnt_t'(3);
            end
            BURST_INCR8: begin
                hburst_map = HBURST_INCR8;
                last_map   = beat_cnt_t'(7);
            end
            BURST_INCR16: begin
                hburst_map = HBURST_INCR16;
                last_map   = beat_cnt_t'(FIFO_DEPTH - 1);
            end
            default: begin
                hburst_map = HBURST_SINGLE;
                last_map   = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            write_q  <= 1'b0;
            hburst_q <= HBURST_SINGLE;
            beat_q   <= '0;
            last_q   <= '0;
        end else if (i_start) begin
            write_q  <= i_req.write;
            hburst_q <= hburst_map;
            beat_q   <= '0;
            last_q   <= last_map;
        end else if (i_beat_adv) begin
            beat_q <= beat_q + beat_cnt_t'(1);
        end
    end

    // Running address, fixed word step
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            addr_q <= i_req.addr;
        end else if (i_beat_adv) begin
            addr_q <= addr_q + addr_t'(BEAT_BYTES);
        end
    end

    assign o_addr      = addr_q;
    assign o_write     = write_q;
    assign o_hburst    = hburst_q;
    assign o_last_beat = (beat_q == last_q);

endmodule

// File: hdl/ahb_xfer_fsm.sv
module ahb_xfer_fsm (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_req_valid,
    input  logic                      i_write,
    input  logic                      i_last_beat,
    input  ahb_master_pkg::fifo_cnt_t i_wr_cnt,
    input  logic                      i_hready,
    input  logic                      i_hresp,
    output logic                      o_start,
    output logic                      o_beat_adv,
    output ahb_master_pkg::htrans_e   o_htrans,
    output logic                      o_hmastlock,
    output logic                      o_wr_pop,
    output logic                      o_rd_push,
    output logic                      o_busy,
    output logic                      o_err
);
    import ahb_master_pkg::*;

    // State is the kind of address phase on the bus
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_NONSEQ,
        ST_BUSY,
        ST_SEQ,
        ST_LAST      // Final data phase, no address phase
    } xfer_state_e;

    xfer_state_e state_q, state_nxt;
    logic        busy_nxt;
    logic        dphase_q;     // A beat is in its data phase
    logic        addr_beat;    // NONSEQ or SEQ on the bus
    fifo_cnt_t   wr_need;
    logic        wr_ready;
    htrans_e     htrans_nxt;

    ////////////////////////////////////////
    // Strobes from the current cycle
    ////////////////////////////////////////
    assign addr_beat  = (state_q == ST_NONSEQ) || (state_q == ST_SEQ);
    assign o_start    = i_req_valid && !o_busy;
    assign o_beat_adv = addr_beat && i_hready && !i_last_beat;
    assign o_wr_pop   = dphase_q && i_hready && i_write;
    assign o_rd_push  = dphase_q && i_hready && !i_write;

    // Words left after this edge must cover the beat moving into data phase
    // and the one about to be issued
    assign wr_need  = fifo_cnt_t'(1) + fifo_cnt_t'(addr_beat) + fifo_cnt_t'(o_wr_pop);
    assign wr_ready = !i_write || (i_wr_cnt >= wr_need);

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state_q;
        busy_nxt  = o_busy;
        case (state_q)
            ST_IDLE: begin
                if (o_start) begin
                    busy_nxt = 1'b1;          // Request captured this edge
                end else if (o_busy && wr_ready) begin
                    state_nxt = ST_NONSEQ;
                end
            end
            ST_NONSEQ, ST_SEQ: begin
                if (i_hready) begin
                    if (i_last_beat) begin
                        state_nxt = ST_LAST;
                    end else if (wr_ready) begin
                        state_nxt = ST_SEQ;
                    end else begin
                        state_nxt = ST_BUSY;  // Write data not in yet
                    end
                end
            end
            ST_BUSY: begin
                if (i_hready && wr_ready) begin
                    state_nxt = ST_SEQ;
                end
            end
            default: begin
                if (i_hready) begin
                    state_nxt = ST_IDLE;
                    busy_nxt  = 1'b0;
                end
            end
        endcase
    end

    always_comb begin
        case (state_nxt)
            ST_NONSEQ: htrans_nxt = HTRANS_NONSEQ;
            ST_SEQ:    htrans_nxt = HTRANS_SEQ;
            ST_BUSY:   htrans_nxt = HTRANS_BUSY;
            default:   htrans_nxt = HTRANS_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state_q     <= ST_IDLE;
            dphase_q    <= 1'b0;
            o_htrans    <= HTRANS_IDLE;
            o_hmastlock <= 1'b0;
            o_busy      <= 1'b0;
            o_err       <= 1'b0;
        end else begin
            state_q     <= state_nxt;
            o_htrans    <= htrans_nxt;
            o_hmastlock <= (htrans_nxt != HTRANS_IDLE);  // Held across the burst
            o_busy      <= busy_nxt;
            o_err       <= dphase_q && i_hready && i_hresp;
            if (i_hready) begin
                dphase_q <= addr_beat;
            end
        end
    end

endmodule

// File: hdl/ahb_data_fifo.sv
module ahb_data_fifo #(
    parameter int DEPTH = ahb_master_pkg::FIFO_DEPTH
) (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_push,
    input  ahb_master_pkg::data_t     i_data,
    input  logic                      i_pop,
    output ahb_master_pkg::data_t     o_data,
    output logic                      o_empty,
    output ahb_master_pkg::fifo_cnt_t o_count
);
    import ahb_master_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    data_t     mem [DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    fifo_cnt_t cnt_q;
    logic      do_push;
    logic      do_pop;

    // Wraps at DEPTH, so odd depths work too
    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign do_push = i_push && (cnt_q < fifo_cnt_t'(DEPTH));
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + fifo_cnt_t'(1);
                2'b01:   cnt_q <= cnt_q - fifo_cnt_t'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data  = mem[rd_ptr];    // Head word, no read latency
    assign o_empty = (cnt_q == '0);
    assign o_count = cnt_q;

endmodule

// File: hdl/ahb_master.sv
module ahb_master (
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    // User side
    input  logic                            i_req_valid,
    input  ahb_master_pkg::ahb_req_t        i_req,
    input  logic                            i_wdata_valid,
    input  ahb_master_pkg::data_t           i_wdata,
    output logic                            o_rdata_valid,
    output ahb_master_pkg::data_t           o_rdata,
    output logic                            o_busy,
    output logic                            o_err,
    // AHB side
    output ahb_master_pkg::ahb_addr_phase_t o_ahb,
    output ahb_master_pkg::data_t           o_hwdata,
    input  ahb_master_pkg::data_t           i_hrdata,
    input  logic                            i_hready,
    input  logic                            i_hresp
);
    import ahb_master_pkg::*;

    logic      start;
    logic      beat_adv;
    addr_t     cur_addr;
    logic      req_write;
    hburst_t   req_hburst;
    logic      last_beat;
    htrans_e   htrans;
    logic      mastlock;
    logic      wr_pop;
    logic      rd_push;
    fifo_cnt_t wr_cnt;
    logic      rd_empty;

    ////////////////////////////////////////
    // Request and transfer control
    ////////////////////////////////////////
    ahb_req_regs u_req_regs (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_start     (start),
        .i_req       (i_req),
        .i_beat_adv  (beat_adv),
        .o_addr      (cur_addr),
        .o_write     (req_write),
        .o_hburst    (req_hburst),
        .o_last_beat (last_beat)
    );

    ahb_xfer_fsm u_xfer_fsm (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_req_valid (i_req_valid),
        .i_write     (req_write),
        .i_last_beat (last_beat),
        .i_wr_cnt    (wr_cnt),
        .i_hready    (i_hready),
        .i_hresp     (i_hresp),
        .o_start     (start),
        .o_beat_adv  (beat_adv),
        .o_htrans    (htrans),
        .o_hmastlock (mastlock),
        .o_wr_pop    (wr_pop),
        .o_rd_push   (rd_push),
        .o_busy      (o_busy),
        .o_err       (o_err)
    );

    ////////////////////////////////////////
    // Data buffers
    ////////////////////////////////////////
    ahb_data_fifo #(.DEPTH(FIFO_DEPTH)) u_wr_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (i_wdata_valid),
        .i_data    (i_wdata),
        .i_pop     (wr_pop),
        .o_data    (o_hwdata),       // Head word drives the write data phase
        .o_empty   (),
        .o_count   (wr_cnt)
    );

    // Drained every cycle, the user takes read data as a strobe
    ahb_data_fifo #(.DEPTH(FIFO_DEPTH)) u_rd_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (rd_push),
        .i_data    (i_hrdata),
        .i_pop     (!rd_empty),
        .o_data    (o_rdata),
        .o_empty   (rd_empty),
        .o_count   ()
    );

    assign o_rdata_valid = !rd_empty;

    assign o_ahb = '{
        haddr:     cur_addr,
        htrans:    htrans,
        hburst:    req_hburst,
        hsize:     HSIZE_WORD,
        hwrite:    req_write,
        hmastlock: mastlock
    };

endmodule

// File: verif/ahb_slave_model.sv
module ahb_slave_model #(
    parameter ahb_master_pkg::addr_t ERR_ADDR  = 32'h0000_0f00,
    parameter int                    MEM_WORDS = 1024,
    parameter logic [31:0]           SEED      = 32'd1
) (
    input  logic                            i_clk,
    input  logic                            i_reset_n,
    input  ahb_master_pkg::ahb_addr_phase_t i_ahb,
    input  ahb_master_pkg::data_t           i_hwdata,
    output ahb_master_pkg::data_t           o_hrdata,
    output logic                            o_hready,
    output logic                            o_hresp,
    output int                              o_burst_beats,  // Beats since the last NONSEQ
    output int                              o_fail_cnt
);
    timeunit 1ns;
    timeprecision 1ps;
    import ahb_master_pkg::*;

    data_t           mem [MEM_WORDS];
    ahb_addr_phase_t ap;            // Address phase seen in the cycle before
    logic            dp_valid;      // A transfer is in its data phase
    addr_t           dp_addr;
    logic            dp_write;
    int              wait_left;
    logic            err_first;     // First cycle of the two-cycle error response
    int              burst_len;
    addr_t           next_addr;

    function automatic int word_index(input addr_t a);
        return int'((a >> 2) % addr_t'(MEM_WORDS));
    endfunction

    function automatic int hburst_beats(input hburst_t hb);
        case (hb)
            HBURST_INCR4:  return 4;
            HBURST_INCR8:  return 8;
            HBURST_INCR16: return 16;
            default:       return 1;
        endcase
    endfunction

    // HREADY was high at the last rising edge, so the address phase in ap
    // has moved into its data phase
    task automatic take_address_phase();
        dp_valid = (ap.htrans == HTRANS_NONSEQ) || (ap.htrans == HTRANS_SEQ);
        if (dp_valid) begin
            dp_addr   = ap.haddr;
            dp_write  = ap.hwrite;
            err_first = (ap.haddr == ERR_ADDR);
            wait_left = 0;
            if (($urandom() & 32'd3) == 32'd0) begin
                wait_left = 1 + int'($urandom() & 32'd1);
            end
            if (ap.htrans == HTRANS_NONSEQ) begin
                burst_len     = hburst_beats(ap.hburst);
                o_burst_beats = 1;
            end else begin
                assert (o_burst_beats < burst_len) else begin
                    o_fail_cnt++;
                    $display("Error at %0t ns: SEQ transfer past the end of the burst", $time);
                end
                assert (ap.haddr == next_addr) else begin
                    o_fail_cnt++;
                    $display("Fail at %0t ns: o_ahb.haddr = %0h, expected %0h",
                             $time, ap.haddr, next_addr);
                end
                o_burst_beats++;
            end
            next_addr = ap.haddr + addr_t'(4);
        end
    endtask

    // Response for the rest of the data phase cycle
    task automatic drive_response();
        if (!dp_valid) begin
            o_hready = 1'b1;
            o_hresp  = 1'b0;
        end else if (wait_left > 0) begin
            o_hready = 1'b0;
            o_hresp  = 1'b0;
            wait_left--;
        end else if (err_first) begin
            o_hready  = 1'b0;
            o_hresp   = 1'b1;
            err_first = 1'b0;
        end else begin
            o_hready = 1'b1;
            o_hresp  = (dp_addr == ERR_ADDR);   // Second error cycle
            if (dp_write) begin
                // Data phase ends at the next rising edge
                if (dp_addr != ERR_ADDR) begin
                    mem[word_index(dp_addr)] = i_hwdata;
                end
            end else begin
                o_hrdata = mem[word_index(dp_addr)];
            end
        end
    endtask

    initial begin
        int i;
        void'($urandom(SEED));
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de_0000 ^ data_t'(i * BEAT_BYTES);  // Byte address in the low bits
        end
        o_hrdata      = '0;
        o_hready      = 1'b1;
        o_hresp       = 1'b0;
        ap            = '0;
        dp_valid      = 1'b0;
        dp_addr       = '0;
        dp_write      = 1'b0;
        wait_left     = 0;
        err_first     = 1'b0;
        burst_len     = 1;
        next_addr     = '0;
        o_burst_beats = 0;
        o_fail_cnt    = 0;
        forever begin
            @(negedge i_clk);
            if (!i_reset_n) begin
                ap        = '0;
                dp_valid  = 1'b0;
                wait_left = 0;
                err_first = 1'b0;
                o_hready  = 1'b1;
                o_hresp   = 1'b0;
            end else begin
                if (o_hready) begin
                    take_address_phase();
                end
                drive_response();
                ap = i_ahb;
            end
        end
    end

endmodule

// File: verif/tb_ahb_master.sv
module tb_ahb_master;
    timeunit 1ns;
    timeprecision 1ps;
    import ahb_master_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam int          MAX_CYCLES   = 500;   // Per request
    localparam int          NUM_ENTRIES  = 13;
    localparam addr_t       ERR_ADDR     = 32'h0000_0f00;
    localparam logic [31:0] RAND_SEED    = 32'h1b01_2493;

    typedef struct packed {
        logic        is_write;
        addr_t       addr;
        burst_code_e burst;
        data_t       seed;       // Beat i carries seed + i
        logic        trickle;    // Write data arrives after the request
        logic        exp_err;
    } stim_entry_t;

    logic            clk;
    logic            reset_n;
    logic            req_valid;
    ahb_req_t        req;
    logic            wdata_valid;
    data_t           wdata;
    logic            rdata_valid;
    data_t           rdata;
    logic            busy;
    logic            err;
    ahb_addr_phase_t ahb;
    data_t           hwdata;
    data_t           hrdata;
    logic            hready;
    logic            hresp;
    int              slave_beats;
    int              slave_fails;
    int              errors;
    int              timeouts;
    stim_entry_t     stim [NUM_ENTRIES];

    ahb_master DUT (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_req_valid   (req_valid),
        .i_req         (req),
        .i_wdata_valid (wdata_valid),
        .i_wdata       (wdata),
        .o_rdata_valid (rdata_valid),
        .o_rdata       (rdata),
        .o_busy        (busy),
        .o_err         (err),
        .o_ahb         (ahb),
        .o_hwdata      (hwdata),
        .i_hrdata      (hrdata),
        .i_hready      (hready),
        .i_hresp       (hresp)
    );

    ahb_slave_model #(.ERR_ADDR(ERR_ADDR), .SEED(RAND_SEED)) u_slave (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_ahb         (ahb),
        .i_hwdata      (hwdata),
        .o_hrdata      (hrdata),
        .o_hready      (hready),
        .o_hresp       (hresp),
        .o_burst_beats (slave_beats),
        .o_fail_cnt    (slave_fails)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference rules and checks
    ////////////////////////////////////////
    function automatic int burst_beats(input burst_code_e b);
        case (b)
            BURST_INCR4:  return 4;
            BURST_INCR8:  return 8;
            BURST_INCR16: return 16;
            default:      return 1;
        endcase
    endfunction

    function automatic hburst_t hburst_for(input burst_code_e b);
        case (b)
            BURST_INCR4:  return 3'b011;
            BURST_INCR8:  return 3'b101;
            BURST_INCR16: return 3'b111;
            default:      return 3'b000;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    function automatic void load_table();
        stim[0]  = '{1'b1, 32'h0000_0100, BURST_SINGLE, 32'h1111_0000, 1'b0, 1'b0};
        stim[1]  = '{1'b0, 32'h0000_0100, BURST_SINGLE, 32'h1111_0000, 1'b0, 1'b0};
        stim[2]  = '{1'b1, 32'h0000_0200, BURST_INCR4,  32'h2222_0000, 1'b0, 1'b0};
        stim[3]  = '{1'b1, 32'h0000_0300, BURST_INCR8,  32'h3333_0000, 1'b0, 1'b0};
        stim[4]  = '{1'b1, 32'h0000_0400, BURST_INCR16, 32'h4444_0000, 1'b0, 1'b0};
        stim[5]  = '{1'b0, 32'h0000_0200, BURST_INCR4,  32'h2222_0000, 1'b0, 1'b0};
        stim[6]  = '{1'b0, 32'h0000_0300, BURST_INCR8,  32'h3333_0000, 1'b0, 1'b0};
        stim[7]  = '{1'b0, 32'h0000_0400, BURST_INCR16, 32'h4444_0000, 1'b0, 1'b0};
        stim[8]  = '{1'b1, 32'h0000_0500, BURST_INCR8,  32'h5555_0000, 1'b1, 1'b0};
        stim[9]  = '{1'b0, 32'h0000_0500, BURST_INCR8,  32'h5555_0000, 1'b0, 1'b0};
        stim[10] = '{1'b0, ERR_ADDR,      BURST_SINGLE, 32'h0000_0000, 1'b0, 1'b1};
        stim[11] = '{1'b1, 32'h0000_0600, BURST_INCR16, 32'h6666_0000, 1'b1, 1'b0};
        stim[12] = '{1'b0, 32'h0000_0600, BURST_INCR16, 32'h6666_0000, 1'b0, 1'b0};
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic preload_write_data(input data_t seed, input int len);
        int i;
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            wdata_valid = 1'b1;
            wdata       = seed + data_t'(i);
        end
        @(negedge clk);
        wdata_valid = 1'b0;
    endtask

    task automatic run_entry(input stim_entry_t e);
        int   len;
        int   rd_seen;
        int   err_seen;
        int   pushed;
        int   cycle;
        logic busy_seen;    // HTRANS BUSY while the burst runs
        logic done;
        len       = burst_beats(e.burst);
        rd_seen   = 0;
        err_seen  = 0;
        cycle     = 0;
        busy_seen = 1'b0;
        done      = 1'b0;
        pushed    = (e.is_write && !e.trickle) ? len : 0;
        if (e.is_write && !e.trickle) begin
            preload_write_data(e.seed, len);
        end
        @(negedge clk);
        expect_true(!busy, "DUT still busy when a new request is issued");
        req_valid = 1'b1;
        req       = '{addr: e.addr, write: e.is_write, burst: e.burst};
        while (!done) begin
            @(negedge clk);
            req_valid   = 1'b0;
            wdata_valid = 1'b0;
            cycle++;
            if (cycle == 1) begin
                compare_value("o_busy", 32'(busy), 32'd1);
            end
            if (cycle == 2 && !e.trickle) begin   // First address phase
                compare_value("o_ahb.htrans", 32'(ahb.htrans), 32'(HTRANS_NONSEQ));
                compare_value("o_ahb.haddr", ahb.haddr, e.addr);
                compare_value("o_ahb.hburst", 32'(ahb.hburst), 32'(hburst_for(e.burst)));
                compare_value("o_ahb.hwrite", 32'(ahb.hwrite), 32'(e.is_write));
                compare_value("o_ahb.hsize", 32'(ahb.hsize), 32'd2);
            end
            if (rdata_valid) begin
                if (!e.is_write && !e.exp_err) begin
                    compare_value("o_rdata", rdata, e.seed + data_t'(rd_seen));
                end
                rd_seen++;
            end
            if (err) err_seen++;
            if (busy && ahb.htrans == HTRANS_BUSY) busy_seen = 1'b1;
            if (!busy) begin
                done = 1'b1;
            end else if (cycle >= MAX_CYCLES) begin
                timeouts++;
                $display("Error at %0t ns: o_busy did not fall within %0d cycles",
                         $time, MAX_CYCLES);
                done = 1'b1;
            end else if (e.trickle && pushed < len && (cycle % 3) == 0) begin
                wdata_valid = 1'b1;
                wdata       = e.seed + data_t'(pushed);
                pushed++;
            end
        end
        compare_value("o_rdata_valid count", rd_seen, e.is_write ? 0 : len);
        compare_value("o_err count", err_seen, 32'(e.exp_err));
        compare_value("slave beat count", slave_beats, len);
        if (e.trickle) begin
            expect_true(busy_seen, "no HTRANS BUSY seen during a trickled write");
        end
        repeat (2) begin
            @(negedge clk);
            expect_true(!rdata_valid && !err, "strobe seen after o_busy fell");
            compare_value("o_ahb.htrans", 32'(ahb.htrans), 32'(HTRANS_IDLE));
        end
    endtask

    initial begin
        int idx;
        reset_n     = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        errors      = 0;
        timeouts    = 0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        compare_value("o_ahb.htrans", 32'(ahb.htrans), 32'(HTRANS_IDLE));
        compare_value("o_ahb.hmastlock", 32'(ahb.hmastlock), 32'd0);
        compare_value("o_busy", 32'(busy), 32'd0);
        compare_value("o_rdata_valid", 32'(rdata_valid), 32'd0);
        compare_value("o_err", 32'(err), 32'd0);
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            if (timeouts == 0) begin
                run_entry(stim[idx]);
            end
        end
        $display("Check errors: %0d, slave errors: %0d, timeouts: %0d",
                 errors, slave_fails, timeouts);
        if (errors == 0 && slave_fails == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: ahb_master.f
hdl/ahb_master_pkg.sv
hdl/ahb_req_regs.sv
hdl/ahb_xfer_fsm.sv
hdl/ahb_data_fifo.sv
hdl/ahb_master.sv
verif/ahb_slave_model.sv
verif/tb_ahb_master.sv

// File: Makefile
# Verilator flow for the AHB master testbench
TOP       ?= tb_ahb_master
SEED      ?= 1
LOG       ?= sim.log
FLIST     ?= ahb_master.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides the result, a crash leaves neither message in it
sim: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
